// ==== filelist.f ====
src/ooo_pkg.sv
src/rob.sv
src/issue_router.sv
src/exec_unit.sv
src/cdb_arbiter.sv
src/ooo_core_top.sv
verification/tb_ooo_core.sv

// ==== Makefile ====
.PHONY: all run lint clean

all: run

obj_dir/Vtb_ooo_core: filelist.f src/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_ooo_core

run: obj_dir/Vtb_ooo_core
	@out="$$(./obj_dir/Vtb_ooo_core)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module tb_ooo_core

clean:
	rm -rf obj_dir

// ==== verification/tb_ooo_core.sv ====
`timescale 1ns/1ps

module tb_ooo_core
    import ooo_pkg::*;
();

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 12;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [OP_W-1:0]  op;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  data;
        logic             flush;
        logic [31:0]      accept;
        logic [31:0]      min_cycles;
    } exp_t;

    logic             clk;
    logic             rst;
    logic             commit_hold;
    logic             alloc_en;
    logic [OP_W-1:0]  alloc_op;
    logic [REG_W-1:0] alloc_rd;
    logic [XLEN-1:0]  alloc_a;
    logic [XLEN-1:0]  alloc_b;
    logic [XLEN-1:0]  alloc_pc;
    logic             alloc_pred_taken;
    logic [XLEN-1:0]  alloc_target;
    logic             alloc_ready;
    logic [TAG_W-1:0] alloc_tag;
    logic             commit_en;
    logic [TAG_W-1:0] commit_tag;
    logic [REG_W-1:0] commit_rd;
    logic [XLEN-1:0]  commit_data;
    logic             commit_store;
    logic             commit_flush;
    logic [XLEN-1:0]  redirect_pc;

    exp_t             q[$];
    logic [TAG_W-1:0] next_tag = '0;
    logic [15:0]      lfsr = 16'd81;
    logic [31:0]      cyc = '0;
    logic             hold_q = 1'b0;
    int mismatches = 0;
    int failures = 0;
    int commits = 0;
    int flushes = 0;
    int full_stalls = 0;

    ooo_core_top dut_i (
        .clk(clk), .rst(rst), .commit_hold(commit_hold),
        .alloc_en(alloc_en), .alloc_op(alloc_op), .alloc_rd(alloc_rd),
        .alloc_a(alloc_a), .alloc_b(alloc_b), .alloc_pc(alloc_pc),
        .alloc_pred_taken(alloc_pred_taken), .alloc_target(alloc_target),
        .alloc_ready(alloc_ready), .alloc_tag(alloc_tag),
        .commit_en(commit_en), .commit_tag(commit_tag), .commit_rd(commit_rd),
        .commit_data(commit_data), .commit_store(commit_store),
        .commit_flush(commit_flush), .redirect_pc(redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // hold_q is the hold level seen by the retire edge
    always @(posedge clk) begin
        cyc    <= cyc + 1;
        hold_q <= commit_hold;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // unit latency plus load, result write and retire
    function automatic logic [31:0] min_commit_cycles(input logic [OP_W-1:0] op);
        case (op)
            OP_SUB, OP_STORE: return 32'd4;
            OP_BEQ: return 32'd5;
            default: return 32'd3;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        mismatches++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR time=%0t %s", $time, msg);
        failures++;
    endtask

    task automatic new_instr();
        logic [2:0] r;
        r                = 3'(take_bits(3));
        alloc_op         = (r > 3'd4) ? r - 3'd4 : r;
        alloc_rd         = 5'(take_bits(5));
        alloc_a          = take_bits(32);
        alloc_b          = take_bits(32);
        // equal operands half the time so branches go both ways
        if (alloc_op == OP_BEQ && take_bits(1) == 1) begin
            alloc_b = alloc_a;
        end
        alloc_pc         = take_bits(30) << 2;
        alloc_target     = take_bits(30) << 2;
        alloc_pred_taken = 1'(take_bits(1));
    endtask

    task automatic record_accept();
        exp_t e;
        logic taken;
        taken = (alloc_a == alloc_b);
        assert (alloc_tag == next_tag) else report_mismatch("alloc_tag", next_tag, alloc_tag);
        e.tag        = next_tag;
        e.op         = alloc_op;
        e.rd         = alloc_rd;
        e.flush      = 1'b0;
        e.accept     = cyc + 1;
        e.min_cycles = min_commit_cycles(alloc_op);
        case (alloc_op)
            OP_XOR: e.data = alloc_a ^ alloc_b;
            OP_SUB: e.data = alloc_a - alloc_b;
            OP_BEQ: begin
                e.rd    = '0;
                e.data  = taken ? alloc_target : alloc_pc + 32'd4;
                e.flush = (alloc_pred_taken != taken);
            end
            default: e.data = alloc_a + alloc_b;
        endcase
        q.push_back(e);
        next_tag = next_tag + 1'b1;
    endtask

    task automatic check_commit();
        exp_t e;
        assert (!(commit_en && hold_q)) else report_failure("commit while commit_hold was high");
        if (!commit_en) begin
            assert (!commit_store && !commit_flush)
                else report_failure("store or flush strobe without commit_en");
        end else if (q.size() == 0) begin
            report_failure("commit with no outstanding instruction");
        end else begin
            e = q.pop_front();
            commits++;
            assert (commit_tag == e.tag) else report_mismatch("commit_tag", e.tag, commit_tag);
            assert (commit_rd == e.rd) else report_mismatch("commit_rd", e.rd, commit_rd);
            assert (commit_data == e.data) else report_mismatch("commit_data", e.data, commit_data);
            assert (commit_store == (e.op == OP_STORE))
                else report_mismatch("commit_store", e.op == OP_STORE, commit_store);
            assert (commit_flush == e.flush)
                else report_mismatch("commit_flush", e.flush, commit_flush);
            assert (cyc - e.accept >= e.min_cycles)
                else report_failure("commit arrived sooner than the operation latency allows");
            if (e.flush) begin
                assert (redirect_pc == e.data)
                    else report_mismatch("redirect_pc", e.data, redirect_pc);
                // younger work is squashed and tags restart at zero
                q.delete();
                next_tag = '0;
                flushes++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_commit();
        end
    end

    initial begin
        while (cyc < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles with %0d instructions outstanding", cyc, q.size());
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int sent;
        int gap;
        int hold_left;
        logic pending;
        sent = 0;
        gap = 0;
        hold_left = 0;
        pending = 1'b0;
        rst = 1'b1;
        commit_hold = 1'b0;
        alloc_en = 1'b0;
        alloc_op = OP_ADD;
        alloc_rd = '0;
        alloc_a = '0;
        alloc_b = '0;
        alloc_pc = '0;
        alloc_pred_taken = 1'b0;
        alloc_target = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        assert (!commit_en && !commit_store && !commit_flush && alloc_ready)
            else report_failure("outputs not idle after reset");

        while (sent < NUM_INSTR) begin
            @(negedge clk);
            if (hold_left > 0) begin
                hold_left--;
                commit_hold = 1'b1;
            end else if (take_bits(5) == 0) begin
                // long enough for the buffer to fill
                hold_left = 16 + int'(take_bits(4));
                commit_hold = 1'b1;
            end else begin
                commit_hold = 1'b0;
            end
            if (!pending && gap > 0) begin
                gap--;
                alloc_en = 1'b0;
            end else begin
                if (!pending) begin
                    new_instr();
                    pending = 1'b1;
                end
                alloc_en = 1'b1;
            end
            #1;
            if (q.size() == ROB_DEPTH) begin
                full_stalls++;
                assert (!alloc_ready) else report_failure("alloc_ready high with a full buffer");
            end
            if (alloc_en && alloc_ready) begin
                record_accept();
                sent++;
                pending = 1'b0;
                gap = (take_bits(2) == 3) ? int'(take_bits(2)) : 0;
            end
        end

        @(negedge clk);
        alloc_en = 1'b0;
        commit_hold = 1'b0;
        while (q.size() != 0) begin
            @(negedge clk);
            #1;
        end
        repeat (4) @(negedge clk);

        $display("mismatches %0d, other errors %0d (commits %0d, flushes %0d, full cycles %0d)",
                 mismatches, failures, commits, flushes, full_stalls);
        if (mismatches == 0 && failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src/ooo_core_top.sv ====
`timescale 1ns/1ps

module ooo_core_top
    import ooo_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             commit_hold,

    input  logic             alloc_en,
    input  logic [OP_W-1:0]  alloc_op,
    input  logic [REG_W-1:0] alloc_rd,
    input  logic [XLEN-1:0]  alloc_a,
    input  logic [XLEN-1:0]  alloc_b,
    input  logic [XLEN-1:0]  alloc_pc,
    input  logic             alloc_pred_taken,
    input  logic [XLEN-1:0]  alloc_target,
    output logic             alloc_ready,
    output logic [TAG_W-1:0] alloc_tag,

    output logic             commit_en,
    output logic [TAG_W-1:0] commit_tag,
    output logic [REG_W-1:0] commit_rd,
    output logic [XLEN-1:0]  commit_data,
    output logic             commit_store,
    output logic             commit_flush,
    output logic [XLEN-1:0]  redirect_pc
);

    logic rob_full;
    logic unit_free;
    logic flush;
    logic alloc_ok;

    logic [NUM_UNITS-1:0] start;
    logic [NUM_UNITS-1:0] unit_busy;
    logic [NUM_UNITS-1:0] unit_done;
    logic [NUM_UNITS-1:0] grant;
    logic [NUM_UNITS-1:0][TAG_W-1:0] unit_tag;
    logic [NUM_UNITS-1:0][XLEN-1:0]  unit_data;
    logic [NUM_UNITS-1:0]            unit_taken;

    logic [OP_W-1:0]  issue_op;
    logic [XLEN-1:0]  issue_a;
    logic [XLEN-1:0]  issue_b;
    logic [XLEN-1:0]  issue_pc;
    logic [XLEN-1:0]  issue_target;
    logic [TAG_W-1:0] issue_tag;

    logic             res_en;
    logic [TAG_W-1:0] res_tag;
    logic [XLEN-1:0]  res_data;
    logic             res_taken;

    // no new work in the cycle the buffer flushes
    assign alloc_ready = !rob_full && unit_free && !flush;
    assign alloc_ok    = alloc_en && alloc_ready;

    rob rob_i (
        .clk(clk), .rst(rst), .commit_hold(commit_hold),
        .alloc_en(alloc_en), .alloc_op(alloc_op), .alloc_rd(alloc_rd),
        .alloc_pc(alloc_pc), .alloc_pred_taken(alloc_pred_taken),
        .alloc_target(alloc_target), .alloc_ok(alloc_ok),
        .rob_full(rob_full), .alloc_tag(alloc_tag),
        .res_en(res_en), .res_tag(res_tag), .res_data(res_data), .res_taken(res_taken),
        .commit_en(commit_en), .commit_tag(commit_tag), .commit_rd(commit_rd),
        .commit_data(commit_data), .commit_store(commit_store),
        .commit_flush(commit_flush), .redirect_pc(redirect_pc), .flush(flush)
    );

    issue_router router_i (
        .clk(clk), .rst(rst), .alloc_ok(alloc_ok),
        .alloc_op(alloc_op), .alloc_a(alloc_a), .alloc_b(alloc_b),
        .alloc_pc(alloc_pc), .alloc_target(alloc_target), .alloc_tag(alloc_tag),
        .unit_busy(unit_busy), .unit_free(unit_free), .start(start),
        .issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b),
        .issue_pc(issue_pc), .issue_target(issue_target), .issue_tag(issue_tag)
    );

    for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
        exec_unit unit_i (
            .clk(clk), .rst(rst), .flush(flush), .start(start[i]),
            .issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b),
            .issue_pc(issue_pc), .issue_target(issue_target), .issue_tag(issue_tag),
            .grant(grant[i]), .busy(unit_busy[i]), .done(unit_done[i]),
            .done_tag(unit_tag[i]), .done_data(unit_data[i]), .done_taken(unit_taken[i])
        );
    end

    cdb_arbiter arb_i (
        .clk(clk), .rst(rst), .flush(flush), .done(unit_done),
        .done_tag(unit_tag), .done_data(unit_data), .done_taken(unit_taken),
        .grant(grant), .res_en(res_en), .res_tag(res_tag),
        .res_data(res_data), .res_taken(res_taken)
    );

endmodule

// ==== src/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter
    import ooo_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 flush,
    input  logic [NUM_UNITS-1:0]                 done,
    input  logic [NUM_UNITS-1:0][TAG_W-1:0]      done_tag,
    input  logic [NUM_UNITS-1:0][XLEN-1:0]       done_data,
    input  logic [NUM_UNITS-1:0]                 done_taken,
    output logic [NUM_UNITS-1:0]                 grant,
    output logic                                 res_en,
    output logic [TAG_W-1:0]                     res_tag,
    output logic [XLEN-1:0]                      res_data,
    output logic                                 res_taken
);

    logic [UNIT_IDX_W-1:0] last;
    logic [UNIT_IDX_W-1:0] cand;
    logic [UNIT_IDX_W-1:0] sel;
    logic                  found;

    // search starts just after the last winner
    always_comb begin
        grant = '0;
        sel   = last;
        found = 1'b0;
        for (int k = 1; k <= NUM_UNITS; k++) begin
            cand = last + UNIT_IDX_W'(k);
            if (!found && done[cand]) begin
                sel   = cand;
                found = 1'b1;
            end
        end
        if (found) begin
            grant[sel] = 1'b1;
        end
    end

    assign res_en    = found;
    assign res_tag   = done_tag[sel];
    assign res_data  = done_data[sel];
    assign res_taken = done_taken[sel];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // unit 0 gets first pick
            last <= UNIT_IDX_W'(NUM_UNITS - 1);
        end else if (found) begin
            last <= sel;
        end
    end

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit
    import ooo_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             start,
    input  logic [OP_W-1:0]  issue_op,
    input  logic [XLEN-1:0]  issue_a,
    input  logic [XLEN-1:0]  issue_b,
    input  logic [XLEN-1:0]  issue_pc,
    input  logic [XLEN-1:0]  issue_target,
    input  logic [TAG_W-1:0] issue_tag,
    input  logic             grant,
    output logic             busy,
    output logic             done,
    output logic [TAG_W-1:0] done_tag,
    output logic [XLEN-1:0]  done_data,
    output logic             done_taken
);

    logic [LAT_W-1:0] lat;
    logic [LAT_W-1:0] cnt;
    logic [XLEN-1:0]  result;
    logic             taken;

    assign lat   = op_latency(issue_op);
    assign taken = (issue_op == OP_BEQ) && (issue_a == issue_b);

    always_comb begin
        case (issue_op)
            OP_XOR: begin
                result = issue_a ^ issue_b;
            end
            OP_SUB: begin
                result = issue_a - issue_b;
            end
            OP_BEQ: begin
                // redirect address of the branch
                result = taken ? issue_target : issue_pc + 32'd4;
            end
            default: begin
                result = issue_a + issue_b;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            done <= (lat == 2'd1);
            cnt  <= lat - 2'd1;
        end else if (done && grant) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (busy && !done) begin
            cnt <= cnt - 2'd1;
            if (cnt == 2'd1) begin
                done <= 1'b1;
            end
        end
    end

    // result held until the bus takes it
    always_ff @(posedge clk) begin
        if (start) begin
            done_tag   <= issue_tag;
            done_data  <= result;
            done_taken <= taken;
        end
    end

endmodule

// ==== src/issue_router.sv ====
`timescale 1ns/1ps

module issue_router
    import ooo_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc_ok,
    input  logic [OP_W-1:0]      alloc_op,
    input  logic [XLEN-1:0]      alloc_a,
    input  logic [XLEN-1:0]      alloc_b,
    input  logic [XLEN-1:0]      alloc_pc,
    input  logic [XLEN-1:0]      alloc_target,
    input  logic [TAG_W-1:0]     alloc_tag,
    input  logic [NUM_UNITS-1:0] unit_busy,
    output logic                 unit_free,
    output logic [NUM_UNITS-1:0] start,
    output logic [OP_W-1:0]      issue_op,
    output logic [XLEN-1:0]      issue_a,
    output logic [XLEN-1:0]      issue_b,
    output logic [XLEN-1:0]      issue_pc,
    output logic [XLEN-1:0]      issue_target,
    output logic [TAG_W-1:0]     issue_tag
);

    logic [NUM_UNITS-1:0] idle;
    logic [NUM_UNITS-1:0] pick;
    logic                 found;

    // a unit started last cycle only loads on this edge
    assign idle      = ~unit_busy & ~start;
    assign unit_free = |idle;

    // lowest idle unit wins
    always_comb begin
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (!found && idle[i]) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start <= '0;
        end else begin
            start <= alloc_ok ? pick : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_ok) begin
            issue_op     <= alloc_op;
            issue_a      <= alloc_a;
            issue_b      <= alloc_b;
            issue_pc     <= alloc_pc;
            issue_target <= alloc_target;
            issue_tag    <= alloc_tag;
        end
    end

endmodule

// ==== src/rob.sv ====
`timescale 1ns/1ps

module rob
    import ooo_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             commit_hold,

    input  logic             alloc_en,
    input  logic [OP_W-1:0]  alloc_op,
    input  logic [REG_W-1:0] alloc_rd,
    input  logic [XLEN-1:0]  alloc_pc,
    input  logic             alloc_pred_taken,
    input  logic [XLEN-1:0]  alloc_target,
    input  logic             alloc_ok,
    output logic             rob_full,
    output logic [TAG_W-1:0] alloc_tag,

    input  logic             res_en,
    input  logic [TAG_W-1:0] res_tag,
    input  logic [XLEN-1:0]  res_data,
    input  logic             res_taken,

    output logic             commit_en,
    output logic [TAG_W-1:0] commit_tag,
    output logic [REG_W-1:0] commit_rd,
    output logic [XLEN-1:0]  commit_data,
    output logic             commit_store,
    output logic             commit_flush,
    output logic [XLEN-1:0]  redirect_pc,
    output logic             flush
);

    // per-entry state
    logic [ROB_DEPTH-1:0] valid;
    logic [ROB_DEPTH-1:0] done;
    logic [ROB_DEPTH-1:0] is_store;
    logic [ROB_DEPTH-1:0] is_branch;
    logic [ROB_DEPTH-1:0] pred;
    logic [ROB_DEPTH-1:0] actual;
    logic [REG_W-1:0]     rd_mem    [ROB_DEPTH];
    logic [XLEN-1:0]      data_mem  [ROB_DEPTH];
    logic [XLEN-1:0]      redir_mem [ROB_DEPTH];

    logic [TAG_W-1:0] rd_ptr;
    logic [TAG_W-1:0] wt_ptr;
    logic [TAG_W:0]   count;

    logic do_alloc;
    logic retire;

    assign do_alloc  = alloc_en & alloc_ok;
    assign alloc_tag = wt_ptr;
    assign rob_full  = (count == ROB_DEPTH);

    // head is complete and the core is not frozen
    assign retire = !commit_hold && valid[rd_ptr] && done[rd_ptr];
    assign flush  = retire && is_branch[rd_ptr] && (pred[rd_ptr] != actual[rd_ptr]);

    // control state
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid  <= '0;
            done   <= '0;
            rd_ptr <= '0;
            wt_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_alloc) begin
                valid[wt_ptr] <= 1'b1;
                done[wt_ptr]  <= 1'b0;
                wt_ptr        <= wt_ptr + 1'b1;
            end
            if (res_en) begin
                done[res_tag] <= 1'b1;
            end
            if (retire) begin
                valid[rd_ptr] <= 1'b0;
                done[rd_ptr]  <= 1'b0;
                rd_ptr        <= rd_ptr + 1'b1;
            end
            case ({do_alloc, retire})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // entry payload, written at allocation and at result time
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            is_store[wt_ptr]  <= (alloc_op == OP_STORE);
            is_branch[wt_ptr] <= (alloc_op == OP_BEQ);
            pred[wt_ptr]      <= alloc_pred_taken;
            // a branch never names a destination
            rd_mem[wt_ptr]    <= (alloc_op == OP_BEQ) ? '0 : alloc_rd;
            // a mispredict always goes the way that was not predicted
            redir_mem[wt_ptr] <= alloc_pred_taken ? alloc_pc + 32'd4 : alloc_target;
        end
        if (res_en) begin
            data_mem[res_tag] <= res_data;
            actual[res_tag]   <= res_taken;
        end
    end

    // registered retire strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            commit_en    <= 1'b0;
            commit_store <= 1'b0;
            commit_flush <= 1'b0;
        end else begin
            commit_en    <= retire;
            commit_store <= retire && is_store[rd_ptr];
            commit_flush <= flush;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_tag  <= rd_ptr;
            commit_rd   <= rd_mem[rd_ptr];
            commit_data <= data_mem[rd_ptr];
            redirect_pc <= redir_mem[rd_ptr];
        end
    end

endmodule

// ==== src/ooo_pkg.sv ====
package ooo_pkg;

    localparam int ROB_DEPTH  = 16;
    localparam int TAG_W      = 4;
    localparam int NUM_UNITS  = 4;
    localparam int UNIT_IDX_W = 2;
    localparam int XLEN       = 32;
    localparam int REG_W      = 5;
    localparam int OP_W       = 3;
    localparam int LAT_W      = 2;

    // operation codes
    localparam logic [OP_W-1:0] OP_ADD   = 3'd0;
    localparam logic [OP_W-1:0] OP_XOR   = 3'd1;
    localparam logic [OP_W-1:0] OP_SUB   = 3'd2;
    localparam logic [OP_W-1:0] OP_STORE = 3'd3;
    localparam logic [OP_W-1:0] OP_BEQ   = 3'd4;

    // cycles a unit spends on each operation
    function automatic logic [LAT_W-1:0] op_latency(input logic [OP_W-1:0] op);
        case (op)
            OP_ADD, OP_XOR: begin
                op_latency = 2'd1;
            end
            OP_SUB, OP_STORE: begin
                op_latency = 2'd2;
            end
            OP_BEQ: begin
                op_latency = 2'd3;
            end
            default: begin
                op_latency = 2'd1;
            end
        endcase
    endfunction

endpackage
